// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_spi_master
FLIST = flist.f
LOG   = sim.log
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: flist.f
spi_cmd_pkg.sv
spi_link_pkg.sv
spi_cmd_stage.sv
spi_shift_engine.sv
spi_read_stage.sv
spi_master_top.sv
tb_spi_slave_model.sv
tb_spi_master.sv

// File: spi_cmd_pkg.sv
package spi_cmd_pkg;

  // register address and read byte.
  typedef logic [2:0] reg_addr_t;
  typedef logic [7:0] rd_data_t;

  // write command, bit 11 set.
  typedef struct packed {
    logic      wr_flag;
    reg_addr_t addr;
    logic [7:0] data;
  } wr_view_t;

  // read command, bit 11 clear; low byte is don't care.
  typedef struct packed {
    logic      wr_flag;
    reg_addr_t addr;
    logic [7:0] unused;
  } rd_view_t;

  // one 12-bit word, decoded by its top bit.
  typedef union packed {
    wr_view_t wr;
    rd_view_t rd;
  } cmd_word_t;

endpackage

// File: spi_cmd_stage.sv
module spi_cmd_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::cmd_word_t cmd_in,
  input  logic                   cmd_vld,
  input  logic                   take,
  output logic                   cmd_rdy,
  output logic                   hold_vld,
  output spi_cmd_pkg::cmd_word_t hold_cmd
);

  logic accept;

  // ready while empty, or while the engine drains the entry this cycle.
  assign cmd_rdy = !hold_vld || take;
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_vld <= 1'b0;
    end
    else if (accept)
    begin
      // refill wins over take in the same cycle.
      hold_vld <= 1'b1;
    end
    else if (take)
    begin
      hold_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      hold_cmd <= cmd_in;
    end
  end

endmodule

// File: spi_link_pkg.sv
package spi_link_pkg;

  // engine phases; a write runs addr_shift then data_shift in one frame.
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_ADDR_SHIFT,
    PH_DATA_SHIFT,
    PH_READ_GAP,
    PH_READ_SHIFT,
    PH_FINISH
  } link_phase_t;

  // frame lengths in sclk periods.
  localparam int WR_FRAME_BITS = 12;
  localparam int RD_ADDR_BITS  = 4;
  localparam int RD_DATA_BITS  = 8;

endpackage

// File: spi_master_top.sv
module spi_master_top #(
  parameter int SCLK_HALF = 4,
  parameter int READ_GAP  = 100
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::cmd_word_t cmd_in,
  input  logic                   cmd_vld,
  input  logic                   miso,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  output logic                   read_vld,
  output spi_cmd_pkg::reg_addr_t read_addr,
  output spi_cmd_pkg::rd_data_t  read_data
);

  logic                   hold_vld;
  spi_cmd_pkg::cmd_word_t hold_cmd;
  logic                   take;
  logic                   cap_vld;
  spi_cmd_pkg::reg_addr_t cap_addr;
  spi_cmd_pkg::rd_data_t  cap_data;

  spi_cmd_stage u_cmd_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .take     (take),
    .cmd_rdy  (cmd_rdy),
    .hold_vld (hold_vld),
    .hold_cmd (hold_cmd)
  );

  spi_shift_engine #(
    .SCLK_HALF (SCLK_HALF),
    .READ_GAP  (READ_GAP)
  ) u_shift_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold_vld (hold_vld),
    .hold_cmd (hold_cmd),
    .miso     (miso),
    .take     (take),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .cap_vld  (cap_vld),
    .cap_addr (cap_addr),
    .cap_data (cap_data)
  );

  spi_read_stage u_read_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .cap_vld   (cap_vld),
    .cap_addr  (cap_addr),
    .cap_data  (cap_data),
    .read_vld  (read_vld),
    .read_addr (read_addr),
    .read_data (read_data)
  );

endmodule

// File: spi_read_stage.sv
module spi_read_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cap_vld,
  input  spi_cmd_pkg::reg_addr_t cap_addr,
  input  spi_cmd_pkg::rd_data_t  cap_data,
  output logic                   read_vld,
  output spi_cmd_pkg::reg_addr_t read_addr,
  output spi_cmd_pkg::rd_data_t  read_data
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= cap_vld;
    end
  end

  // address and byte hold until the next completed read.
  always_ff @(posedge clk)
  begin
    if (cap_vld)
    begin
      read_addr <= cap_addr;
      read_data <= cap_data;
    end
  end

endmodule

// File: spi_shift_engine.sv
module spi_shift_engine #(
  parameter int SCLK_HALF = 4,
  parameter int READ_GAP  = 100
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   hold_vld,
  input  spi_cmd_pkg::cmd_word_t hold_cmd,
  input  logic                   miso,
  output logic                   take,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  output logic                   cap_vld,
  output spi_cmd_pkg::reg_addr_t cap_addr,
  output spi_cmd_pkg::rd_data_t  cap_data
);

  localparam int HALF_W  = $clog2(SCLK_HALF + 1);
  localparam int GAP_MAX = (READ_GAP > SCLK_HALF) ? READ_GAP : SCLK_HALF;
  localparam int GAP_W   = $clog2(GAP_MAX + 1);
  localparam int BIT_W   = $clog2(spi_link_pkg::WR_FRAME_BITS + 1);
  localparam int TX_W    = spi_link_pkg::WR_FRAME_BITS;

  localparam logic [BIT_W-1:0] ADDR_LAST = BIT_W'(spi_link_pkg::RD_ADDR_BITS - 1);
  localparam logic [BIT_W-1:0] WR_LAST   = BIT_W'(spi_link_pkg::WR_FRAME_BITS - 1);
  localparam logic [BIT_W-1:0] RD_LAST   = BIT_W'(spi_link_pkg::RD_DATA_BITS - 1);

  spi_link_pkg::link_phase_t phase;

  logic [HALF_W-1:0] half_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic [GAP_W-1:0]  gap_cnt;
  logic [TX_W-1:0]   tx_sh;
  logic              is_read;
  logic              mosi_upd;
  logic              tx_phase;
  logic              frame_start;
  logic              shifting;
  logic              half_end;
  logic              sclk_rise;
  logic              sclk_fall;

  assign take     = (phase == spi_link_pkg::PH_IDLE) && hold_vld;
  assign tx_phase = (phase == spi_link_pkg::PH_ADDR_SHIFT) ||
                    (phase == spi_link_pkg::PH_DATA_SHIFT);

  // a shift phase entered with cs_n still high opens a new frame.
  assign frame_start = cs_n && ((phase == spi_link_pkg::PH_ADDR_SHIFT) ||
                                (phase == spi_link_pkg::PH_READ_SHIFT));
  assign shifting    = !cs_n && (tx_phase || (phase == spi_link_pkg::PH_READ_SHIFT));
  assign half_end    = (half_cnt == HALF_W'(SCLK_HALF - 1));
  assign sclk_rise   = shifting && half_end && !sclk;
  assign sclk_fall   = shifting && half_end && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase    <= spi_link_pkg::PH_IDLE;
      cs_n     <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
      mosi_upd <= 1'b0;
      cap_vld  <= 1'b0;
    end
    else
    begin
      mosi_upd <= 1'b0;
      if (frame_start)
      begin
        cs_n     <= 1'b0;
        half_cnt <= '0;
        bit_cnt  <= '0;
        // first mosi bit goes out one cycle after cs_n falls.
        mosi_upd <= tx_phase;
      end
      else if (shifting)
      begin
        gap_cnt <= '0;
        if (half_end)
        begin
          half_cnt <= '0;
          sclk     <= ~sclk;
        end
        else
        begin
          half_cnt <= half_cnt + 1'b1;
        end
        if (sclk_fall)
        begin
          bit_cnt  <= bit_cnt + 1'b1;
          mosi_upd <= 1'b1;
        end
      end

      if (tx_phase && mosi_upd)
      begin
        mosi <= tx_sh[TX_W-1];
      end
      else if (!tx_phase)
      begin
        mosi <= 1'b0;
      end

      // one cycle after the last rising edge of a read data frame.
      cap_vld <= (phase == spi_link_pkg::PH_READ_SHIFT) && !cs_n && sclk &&
                 (half_cnt == '0) && (bit_cnt == RD_LAST);

      case (phase)
        spi_link_pkg::PH_IDLE:
        begin
          if (take)
            phase <= spi_link_pkg::PH_ADDR_SHIFT;
        end
        spi_link_pkg::PH_ADDR_SHIFT:
        begin
          if (sclk_fall && (bit_cnt == ADDR_LAST))
            phase <= is_read ? spi_link_pkg::PH_READ_GAP : spi_link_pkg::PH_DATA_SHIFT;
        end
        spi_link_pkg::PH_DATA_SHIFT:
        begin
          if (sclk_fall && (bit_cnt == WR_LAST))
            phase <= spi_link_pkg::PH_FINISH;
        end
        spi_link_pkg::PH_READ_GAP:
        begin
          // cs_n high for exactly READ_GAP cycles before the data frame.
          cs_n    <= 1'b1;
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_W'(READ_GAP - 1))
            phase <= spi_link_pkg::PH_READ_SHIFT;
        end
        spi_link_pkg::PH_READ_SHIFT:
        begin
          if (sclk_fall && (bit_cnt == RD_LAST))
            phase <= spi_link_pkg::PH_FINISH;
        end
        spi_link_pkg::PH_FINISH:
        begin
          cs_n    <= 1'b1;
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_W'(SCLK_HALF - 1))
            phase <= spi_link_pkg::PH_IDLE;
        end
        default:
        begin
          phase <= spi_link_pkg::PH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      is_read  <= !hold_cmd.wr.wr_flag;
      cap_addr <= hold_cmd.rd.addr;
      if (hold_cmd.wr.wr_flag)
        tx_sh <= {hold_cmd.wr.wr_flag, hold_cmd.wr.addr, hold_cmd.wr.data};
      else
        tx_sh <= {hold_cmd.rd.wr_flag, hold_cmd.rd.addr, {spi_link_pkg::RD_DATA_BITS{1'b0}}};
    end
    else if (tx_phase && mosi_upd)
    begin
      tx_sh <= {tx_sh[TX_W-2:0], 1'b0};
    end

    // miso sampled on rising sclk, msb first.
    if (sclk_rise && (phase == spi_link_pkg::PH_READ_SHIFT))
    begin
      cap_data <= {cap_data[6:0], miso};
    end
  end

endmodule

// File: tb_spi_master.sv
module tb_spi_master;

  localparam int SCLK_HALF    = 2;
  localparam int READ_GAP     = 20;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_CMDS    = 40;
  // every command of every test finishes well inside CMD_CYCLES.
  localparam int TOTAL_CMDS     = 8 + 16 + 12 + RAND_CMDS + 8;
  localparam int CMD_CYCLES     = 200;
  localparam int TIMEOUT_CYCLES = TOTAL_CMDS * CMD_CYCLES + 3200;

  logic                   clk;
  logic                   rst_n;
  spi_cmd_pkg::cmd_word_t cmd_in;
  logic                   cmd_vld;
  logic                   cmd_rdy;
  logic                   sclk;
  logic                   cs_n;
  logic                   mosi;
  logic                   miso;
  logic                   read_vld;
  spi_cmd_pkg::reg_addr_t read_addr;
  spi_cmd_pkg::rd_data_t  read_data;

  spi_cmd_pkg::rd_data_t  shadow [0:7];
  spi_cmd_pkg::reg_addr_t exp_addr_q [$];
  spi_cmd_pkg::rd_data_t  exp_data_q [$];
  logic [31:0]            lcg_state = 32'd99;
  string                  cur_test = "reset_state";
  int                     value_errs = 0;
  int                     proto_errs = 0;
  int                     reads_issued = 0;
  int                     reads_seen = 0;
  int                     stall_cnt = 0;
  int                     cycle_cnt = 0;
  logic                   mon_en = 1'b0;
  logic                   prev_sclk = 1'b0;
  logic                   prev_cs = 1'b1;
  logic                   want_data = 1'b0;
  logic                   gap_open = 1'b0;
  int                     edge_cnt = 0;
  int                     gap_len = 0;

  spi_master_top #(
    .SCLK_HALF (SCLK_HALF),
    .READ_GAP  (READ_GAP)
  ) u_spi_master_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_addr (read_addr),
    .read_data (read_data)
  );

  tb_spi_slave_model u_slave_model (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    for (int i = 0; i < 8; i++)
      shadow[i] = 8'(i * 17 + 3);
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // expected byte of a read as of the moment it is issued.
  function automatic spi_cmd_pkg::rd_data_t exp_read(input spi_cmd_pkg::reg_addr_t addr);
    return shadow[addr];
  endfunction

  function automatic spi_cmd_pkg::cmd_word_t make_write(input spi_cmd_pkg::reg_addr_t addr,
                                                        input spi_cmd_pkg::rd_data_t data);
    spi_cmd_pkg::cmd_word_t c;
    c.wr.wr_flag = 1'b1;
    c.wr.addr    = addr;
    c.wr.data    = data;
    return c;
  endfunction

  function automatic spi_cmd_pkg::cmd_word_t make_read(input spi_cmd_pkg::reg_addr_t addr);
    spi_cmd_pkg::cmd_word_t c;
    c.rd.wr_flag = 1'b0;
    c.rd.addr    = addr;
    c.rd.unused  = '0;
    return c;
  endfunction

  task automatic check_level(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
    begin
      $display("[ERROR] %s: expected %b actual %b", name, exp_v, act_v);
      value_errs++;
    end
  endtask

  task automatic check_addr(input string name, input spi_cmd_pkg::reg_addr_t exp_v,
                            input spi_cmd_pkg::reg_addr_t act_v);
    if (act_v !== exp_v)
    begin
      $display("[ERROR] %s: read_addr expected %0d actual %0d", name, exp_v, act_v);
      value_errs++;
    end
  endtask

  task automatic check_data(input string name, input spi_cmd_pkg::rd_data_t exp_v,
                            input spi_cmd_pkg::rd_data_t act_v);
    if (act_v !== exp_v)
    begin
      $display("[ERROR] %s: read_data expected 0x%02h actual 0x%02h", name, exp_v, act_v);
      value_errs++;
    end
  endtask

  task automatic check_idle_levels();
    check_level("reset_state cmd_rdy", 1'b1, cmd_rdy);
    check_level("reset_state cs_n", 1'b1, cs_n);
    check_level("reset_state sclk", 1'b0, sclk);
    check_level("reset_state read_vld", 1'b0, read_vld);
  endtask

  // cmd_rdy only moves on rising edges and the falling-edge value holds for the next take.
  task automatic send_cmd(input spi_cmd_pkg::cmd_word_t c);
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      stall_cnt++;
      @(negedge clk);
    end
    if (c.wr.wr_flag)
      shadow[c.wr.addr] = c.wr.data;
    else
    begin
      exp_addr_q.push_back(c.rd.addr);
      exp_data_q.push_back(exp_read(c.rd.addr));
      reads_issued++;
    end
  endtask

  task automatic release_bus(input int idle);
    @(negedge clk);
    cmd_vld = 1'b0;
    repeat (idle) @(negedge clk);
  endtask

  task automatic wait_drain();
    release_bus(0);
    while (exp_addr_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic print_totals();
    $display("errors: %0d value, %0d protocol, %0d slave frame",
             value_errs, proto_errs, u_slave_model.frame_errs);
  endtask

  always @(negedge clk)
  begin
    if (read_vld === 1'b1)
    begin
      reads_seen++;
      if (exp_addr_q.size() == 0)
      begin
        $display("read_vld pulsed with no read outstanding at cycle %0d", cycle_cnt);
        proto_errs++;
      end
      else
      begin
        check_addr(cur_test, exp_addr_q.pop_front(), read_addr);
        check_data(cur_test, exp_data_q.pop_front(), read_data);
      end
    end
  end

  // framing seen at the pins.
  always @(negedge clk)
  begin
    if (mon_en)
    begin
      if (sclk && cs_n)
      begin
        $display("sclk high while cs_n high at cycle %0d", cycle_cnt);
        proto_errs++;
      end
      if (sclk && !prev_sclk)
        edge_cnt++;
      if (prev_cs && !cs_n)
      begin
        if (gap_open && gap_len < READ_GAP)
        begin
          $display("read gap lasted %0d cycles, less than %0d", gap_len, READ_GAP);
          proto_errs++;
        end
        want_data = gap_open;
        gap_open  = 1'b0;
        edge_cnt  = 0;
      end
      else if (!prev_cs && cs_n)
      begin
        if (want_data ? (edge_cnt != spi_link_pkg::RD_DATA_BITS) :
            (edge_cnt != spi_link_pkg::WR_FRAME_BITS && edge_cnt != spi_link_pkg::RD_ADDR_BITS))
        begin
          $display("frame ended after %0d sclk edges at cycle %0d", edge_cnt, cycle_cnt);
          proto_errs++;
        end
        gap_open = !want_data && (edge_cnt == spi_link_pkg::RD_ADDR_BITS);
        gap_len  = 1;
      end
      else if (cs_n && gap_open)
        gap_len++;
      prev_sclk = sclk;
      prev_cs   = cs_n;
    end
  end

  initial
  begin
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d reads outstanding",
             TIMEOUT_CYCLES, exp_addr_q.size());
    print_totals();
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] r;
    int          stall_before;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rst_n   = 1'b1;
    @(negedge clk);
    rst_n = 1'b0;
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_idle_levels();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_levels();
    mon_en = 1'b1;

    cur_test = "unwritten_reads";
    for (int a = 0; a < 8; a++)
      send_cmd(make_read(3'(a)));
    wait_drain();

    cur_test = "write_readback";
    for (int a = 0; a < 8; a++)
    begin
      r = lcg_next();
      send_cmd(make_write(3'(a), r[23:16]));
      send_cmd(make_read(3'(a)));
    end
    wait_drain();

    cur_test = "back_to_back";
    stall_before = stall_cnt;
    for (int k = 0; k < 6; k++)
    begin
      r = lcg_next();
      send_cmd(make_write(r[30:28], r[23:16]));
      send_cmd(make_read(r[30:28] ^ 3'(k)));
    end
    wait_drain();
    if (stall_cnt == stall_before)
    begin
      $display("cmd_rdy never dropped while commands were issued back to back");
      proto_errs++;
    end

    cur_test = "random_mix";
    for (int n = 0; n < RAND_CMDS; n++)
    begin
      r = lcg_next();
      if (r[27])
        send_cmd(make_write(r[30:28], r[23:16]));
      else
        send_cmd(make_read(r[30:28]));
      if (r[26:25] == 2'b00)
        release_bus(int'(r[22:19]));
    end
    wait_drain();

    cur_test = "final_reads";
    for (int a = 0; a < 8; a++)
      send_cmd(make_read(3'(a)));
    wait_drain();

    if (reads_seen != reads_issued)
    begin
      $display("%0d reads issued but %0d returned", reads_issued, reads_seen);
      proto_errs++;
    end
    print_totals();
    if (value_errs + proto_errs + u_slave_model.frame_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb_spi_slave_model.sv
module tb_spi_slave_model (
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [0:7];
  logic [11:0] rx_sh;
  logic [7:0]  tx_sh;
  logic [2:0]  rd_addr;
  logic        armed;
  logic        in_data;
  logic        first_bit;
  int          bit_cnt;
  int          frame_errs = 0;

  initial miso = 1'b0;

  always @(negedge rst_n)
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'(i * 17 + 3);
    armed   = 1'b0;
    in_data = 1'b0;
    bit_cnt = 0;
    miso    = 1'b0;
  end

  // a frame opened while armed is the data frame that follows the read gap.
  always @(negedge cs_n)
  begin
    if (rst_n)
    begin
      bit_cnt = 0;
      in_data = armed;
      tx_sh   = regs[rd_addr];
      miso    = in_data ? tx_sh[7] : 1'b0;
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_sh = {rx_sh[10:0], mosi};
      bit_cnt++;
      if (bit_cnt == 1)
        first_bit = mosi;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs_n && in_data)
    begin
      tx_sh = {tx_sh[6:0], 1'b0};
      miso  = tx_sh[7];
    end
  end

  always @(posedge cs_n)
  begin
    if (rst_n)
    begin
      if (in_data)
      begin
        armed   = 1'b0;
        in_data = 1'b0;
        miso    = 1'b0;
      end
      else if (first_bit)
      begin
        if (bit_cnt == spi_link_pkg::WR_FRAME_BITS)
          regs[rx_sh[10:8]] = rx_sh[7:0];
        else
        begin
          $display("slave model: write frame carried %0d bits", bit_cnt);
          frame_errs++;
        end
      end
      else if (bit_cnt == spi_link_pkg::RD_ADDR_BITS)
      begin
        rd_addr = rx_sh[2:0];
        armed   = 1'b1;
      end
      else
      begin
        $display("slave model: read address frame carried %0d bits", bit_cnt);
        frame_errs++;
      end
    end
  end

endmodule
